// ==== verilog/vid_pkg.sv ====
/*
 * shared definitions for the bitmap video controller
 * geometry, memory organisation, register numbers, bus encodings, word types
 */
`default_nettype none

package vid_pkg;

    // display geometry, kept tiny so a frame simulates fast
    localparam int H_VISIBLE    = 32;   // visible pixels per line
    localparam int H_TOTAL      = 40;   // pixel periods per line
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 37;   // first pixel after hsync
    localparam int V_VISIBLE    = 8;
    localparam int V_TOTAL      = 10;
    localparam int V_SYNC_LINE  = 9;

    // pixel and memory organisation
    localparam int PIX_PER_WORD   = 4;    // 4bpp, high nibble first
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_BANKS      = 4;    // interleaved on low address bits
    localparam int BANK_DEPTH     = 256;
    localparam int VRAM_AW        = 10;   // 1024 words total
    localparam int PAL_ENTRIES    = 16;

    // host register numbers
    localparam int REG_ADDR = 0;
    localparam int REG_DATA = 1;
    localparam int REG_PAL  = 2;
    localparam int REG_CTRL = 3;

    // bus encodings
    localparam logic CS_ENABLED = 1'b0;
    localparam logic RNW_READ   = 1'b1;
    localparam logic RNW_WRITE  = 1'b0;

    typedef logic [15:0]        vram_word_t;
    typedef logic [11:0]        rgb_t;          // r [11:8], g [7:4], b [3:0]
    typedef logic [VRAM_AW-1:0] vram_addr_t;

endpackage

`default_nettype wire

// ==== verilog/sync_ram.sv ====
/*
 * single-port synchronous RAM, inferred block RAM
 * payload type set by parameter, used for vram banks and palette
 */
`default_nettype none
`timescale 1ns/1ns

module sync_ram #(
    parameter type data_t = logic [15:0],
    parameter int  DEPTH  = 256
) (
    input  wire logic                     clk,
    input  wire logic                     sel_i,    // access this cycle
    input  wire logic                     we_i,     // write when selected
    input  wire logic [$clog2(DEPTH)-1:0] addr_i,
    input  wire data_t                    wdata_i,
    output      data_t                    rdata_o   // valid the cycle after a read
);

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;     // rdata_o keeps old value on write
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/host_regs.sv ====
/*
 * host bus register file with high byte latch and auto-incrementing address
 * vram request generation, read-ahead latch, palette write strobe
 */
`default_nettype none
`timescale 1ns/1ns

module host_regs (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                bus_cs_n_i,        // one access per low cycle
    input  wire logic                bus_rd_nwr_i,
    input  wire logic [1:0]          bus_reg_num_i,
    input  wire logic                bus_bytesel_i,     // 0 = high byte, 1 = low byte
    input  wire logic [7:0]          bus_data_i,
    input  wire logic                host_req_ready_i,
    input  wire logic                host_rdata_valid_i,
    input  wire vid_pkg::vram_word_t rdata_i,
    output      logic [7:0]          bus_data_o,
    output      logic                host_req_valid_o,
    output      logic                host_req_we_o,
    output      vid_pkg::vram_addr_t host_req_addr_o,
    output      vid_pkg::vram_word_t host_req_wdata_o,
    output      logic                pal_we_o,
    output      logic [3:0]          pal_idx_o,
    output      vid_pkg::rgb_t       pal_wdata_o,
    output      logic                video_enable_o
);

    logic                bus_wr;        // write access this cycle
    logic                bus_rd;
    logic                lo_wr;         // low byte write, register takes effect
    logic [7:0]          hi_byte;       // held until the low byte arrives
    vid_pkg::vram_word_t wr_word;       // full 16-bit write value
    vid_pkg::vram_addr_t addr_reg;
    vid_pkg::vram_word_t rd_latch;      // last word returned from vram
    vid_pkg::vram_word_t ctrl_reg;
    vid_pkg::vram_word_t rd_word;       // register selected for readback

    assign bus_wr  = (bus_cs_n_i == vid_pkg::CS_ENABLED) && (bus_rd_nwr_i == vid_pkg::RNW_WRITE);
    assign bus_rd  = (bus_cs_n_i == vid_pkg::CS_ENABLED) && (bus_rd_nwr_i == vid_pkg::RNW_READ);
    assign lo_wr   = bus_wr && bus_bytesel_i;
    assign wr_word = {hi_byte, bus_data_i};

    // palette goes straight through, entry picked by the address register
    assign pal_we_o       = lo_wr && (bus_reg_num_i == vid_pkg::REG_PAL);
    assign pal_idx_o      = addr_reg[3:0];
    assign pal_wdata_o    = wr_word[11:0];
    assign video_enable_o = ctrl_reg[0];

    always_comb begin
        case (bus_reg_num_i)
            2'(vid_pkg::REG_ADDR): rd_word = 16'(addr_reg);
            2'(vid_pkg::REG_DATA): rd_word = rd_latch;
            2'(vid_pkg::REG_CTRL): rd_word = ctrl_reg;
            default:               rd_word = '0;    // palette is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus_wr && !bus_bytesel_i) begin
            hi_byte <= bus_data_i;
        end
        if (host_rdata_valid_i) begin
            rd_latch <= rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_req_valid_o <= 1'b0;
            addr_reg         <= '0;
            ctrl_reg         <= '0;
            bus_data_o       <= '0;
        end else begin
            if (host_req_valid_o && host_req_ready_i) begin
                host_req_valid_o <= 1'b0;
                if (host_req_we_o) begin
                    addr_reg <= addr_reg + 1'b1;    // read-ahead leaves address alone
                end
            end
            if (lo_wr) begin
                case (bus_reg_num_i)
                    2'(vid_pkg::REG_ADDR): begin
                        addr_reg <= wr_word[vid_pkg::VRAM_AW-1:0];  // wins over increment
                        if (!host_req_valid_o) begin                 // read-ahead
                            host_req_valid_o <= 1'b1;
                            host_req_we_o    <= 1'b0;
                            host_req_addr_o  <= wr_word[vid_pkg::VRAM_AW-1:0];
                        end
                    end
                    2'(vid_pkg::REG_DATA): begin
                        if (!host_req_valid_o) begin    // dropped while one is pending
                            host_req_valid_o <= 1'b1;
                            host_req_we_o    <= 1'b1;
                            host_req_addr_o  <= addr_reg;
                            host_req_wdata_o <= wr_word;
                        end
                    end
                    2'(vid_pkg::REG_CTRL): ctrl_reg <= wr_word;
                    default: ;                          // palette handled above
                endcase
            end
            if (bus_rd) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vram_arbiter.sv ====
/*
 * vram arbiter, video fetch always wins over host request
 * registered bank select, shared address and write data, read tag
 */
`default_nettype none
`timescale 1ns/1ns

module vram_arbiter (
    input  wire logic                                    clk,
    input  wire logic                                    reset_i,
    input  wire logic                                    fetch_valid_i,
    input  wire vid_pkg::vram_addr_t                     fetch_addr_i,
    input  wire logic                                    host_req_valid_i,
    input  wire logic                                    host_req_we_i,
    input  wire vid_pkg::vram_addr_t                     host_req_addr_i,
    input  wire vid_pkg::vram_word_t                     host_req_wdata_i,
    output      logic                                    host_req_ready_o,
    output      logic [vid_pkg::NUM_BANKS-1:0]           bank_sel_o,
    output      logic                                    bank_we_o,
    output      logic [$clog2(vid_pkg::BANK_DEPTH)-1:0]  bank_addr_o,
    output      vid_pkg::vram_word_t                     bank_wdata_o,
    output      logic                                    tag_read_o,
    output      logic                                    tag_vid_o,
    output      logic [$clog2(vid_pkg::NUM_BANKS)-1:0]   tag_bank_o
);

    logic                gnt;           // some access this cycle
    logic                gnt_we;
    vid_pkg::vram_addr_t gnt_addr;

    // host only gets the slot when video is idle
    assign host_req_ready_o = !fetch_valid_i;
    assign gnt              = fetch_valid_i || host_req_valid_i;
    assign gnt_we           = !fetch_valid_i && host_req_we_i;
    assign gnt_addr         = fetch_valid_i ? fetch_addr_i : host_req_addr_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bank_sel_o <= '0;
            tag_read_o <= 1'b0;
        end else begin
            bank_sel_o <= '0;
            if (gnt) begin
                bank_sel_o[gnt_addr[$clog2(vid_pkg::NUM_BANKS)-1:0]] <= 1'b1;
            end
            tag_read_o <= gnt && !gnt_we;   // writes return nothing
        end
    end

    // payload, qualified by bank_sel_o and tag_read_o
    always_ff @(posedge clk) begin
        bank_we_o    <= gnt_we;
        bank_addr_o  <= gnt_addr[vid_pkg::VRAM_AW-1:$clog2(vid_pkg::NUM_BANKS)];
        bank_wdata_o <= host_req_wdata_i;
        tag_vid_o    <= fetch_valid_i;
        tag_bank_o   <= gnt_addr[$clog2(vid_pkg::NUM_BANKS)-1:0];
    end

endmodule

`default_nettype wire

// ==== verilog/vram_read_return.sv ====
/*
 * vram read return, tag delayed to match bank latency
 * bank output mux and per-requester data valid
 */
`default_nettype none
`timescale 1ns/1ns

module vram_read_return (
    input  wire logic                                  clk,
    input  wire logic                                  reset_i,
    input  wire logic                                  tag_read_i,
    input  wire logic                                  tag_vid_i,
    input  wire logic [$clog2(vid_pkg::NUM_BANKS)-1:0] tag_bank_i,
    input  wire vid_pkg::vram_word_t                   bank_rdata_i [vid_pkg::NUM_BANKS],
    output      vid_pkg::vram_word_t                   rdata_o,
    output      logic                                  vid_rdata_valid_o,
    output      logic                                  host_rdata_valid_o
);

    logic                                  read_q;     // bank data present now
    logic                                  vid_q;
    logic [$clog2(vid_pkg::NUM_BANKS)-1:0] bank_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            read_q <= 1'b0;
        end else begin
            read_q <= tag_read_i;
        end
        vid_q  <= tag_vid_i;
        bank_q <= tag_bank_i;
    end

    assign rdata_o            = bank_rdata_i[bank_q];
    assign vid_rdata_valid_o  = read_q && vid_q;
    assign host_rdata_valid_o = read_q && !vid_q;

endmodule

`default_nettype wire

// ==== verilog/video_engine.sv ====
/*
 * display engine: raster counters, sync generation, vram fetch schedule
 * pixel shifter, palette lookup, colour and sync output registers
 */
`default_nettype none
`timescale 1ns/1ns

module video_engine (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                enable_i,
    input  wire logic                vid_rdata_valid_i,
    input  wire vid_pkg::vram_word_t rdata_i,
    input  wire logic                pal_we_i,
    input  wire logic [3:0]          pal_idx_i,
    input  wire vid_pkg::rgb_t       pal_wdata_i,
    output      logic                fetch_valid_o,
    output      vid_pkg::vram_addr_t fetch_addr_o,
    output      logic [3:0]          red_o,
    output      logic [3:0]          green_o,
    output      logic [3:0]          blue_o,
    output      logic                hsync_o,
    output      logic                vsync_o,
    output      logic                dv_de_o
);

    logic [$clog2(vid_pkg::H_TOTAL)-1:0] h_count;
    logic [$clog2(vid_pkg::V_TOTAL)-1:0] v_count;
    logic                de_raw;        // counter domain, pixel n at h_count n
    logic                hs_raw;
    logic                vs_raw;
    logic [5:0]          de_pipe;       // six stages fetch to rgb register
    logic [5:0]          hs_pipe;
    logic [5:0]          vs_pipe;
    logic [2:0]          ld_pipe;       // fetch strobe delayed to shifter load
    vid_pkg::vram_word_t hold_word;     // returned fetch waits here
    vid_pkg::vram_word_t shift_word;
    logic                pal_sel;
    logic [3:0]          pal_addr;
    vid_pkg::rgb_t       pal_rdata;
    vid_pkg::rgb_t       rgb_q;

    // counters park at zero while disabled
    always_ff @(posedge clk) begin
        if (reset_i || !enable_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == vid_pkg::H_TOTAL - 1) begin
            h_count <= '0;
            if (v_count == vid_pkg::V_TOTAL - 1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign de_raw = enable_i && (h_count < vid_pkg::H_VISIBLE) && (v_count < vid_pkg::V_VISIBLE);
    assign hs_raw = enable_i && (h_count >= vid_pkg::H_SYNC_START) &&
                    (h_count < vid_pkg::H_SYNC_END);
    assign vs_raw = enable_i && (v_count == vid_pkg::V_SYNC_LINE);

    // word k fetched at h 4k, its first pixel leaves the shifter 4 cycles on
    assign fetch_valid_o = de_raw && ((h_count % vid_pkg::PIX_PER_WORD) == 0);
    assign fetch_addr_o  = vid_pkg::VRAM_AW'(v_count * vid_pkg::WORDS_PER_LINE +
                                             h_count / vid_pkg::PIX_PER_WORD);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_pipe <= '0;
            hs_pipe <= '0;
            vs_pipe <= '0;
            ld_pipe <= '0;
            rgb_q   <= '0;
        end else begin
            de_pipe <= {de_pipe[4:0], de_raw};
            hs_pipe <= {hs_pipe[4:0], hs_raw};
            vs_pipe <= {vs_pipe[4:0], vs_raw};
            ld_pipe <= {ld_pipe[1:0], fetch_valid_o};
            rgb_q   <= de_pipe[4] ? pal_rdata : '0;     // black outside display
        end
    end

    always_ff @(posedge clk) begin
        if (vid_rdata_valid_i) begin
            hold_word <= rdata_i;       // lands 2 cycles after fetch
        end
        if (ld_pipe[2]) begin
            shift_word <= hold_word;
        end else begin
            shift_word <= {shift_word[11:0], 4'h0};    // next nibble up
        end
    end

    // host write takes the port over the pixel lookup
    assign pal_sel  = pal_we_i || de_pipe[3];
    assign pal_addr = pal_we_i ? pal_idx_i : shift_word[15:12];

    sync_ram #(
        .data_t (vid_pkg::rgb_t),
        .DEPTH  (vid_pkg::PAL_ENTRIES)
    ) palette (
        .clk     (clk),
        .sel_i   (pal_sel),
        .we_i    (pal_we_i),
        .addr_i  (pal_addr),
        .wdata_i (pal_wdata_i),
        .rdata_o (pal_rdata)
    );

    assign red_o   = rgb_q[11:8];
    assign green_o = rgb_q[7:4];
    assign blue_o  = rgb_q[3:0];
    assign dv_de_o = de_pipe[5];    // lines up with rgb_q
    assign hsync_o = hs_pipe[5];
    assign vsync_o = vs_pipe[5];

endmodule

`default_nettype wire

// ==== verilog/vidcore_top.sv ====
/*
 * top level of the bitmap video controller
 * host registers, vram arbiter, banked vram, read return, display engine
 */
`default_nettype none
`timescale 1ns/1ns

module vidcore_top (
    input  wire logic       clk,            // pixel clock
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,
    input  wire logic       bus_rd_nwr_i,
    input  wire logic [1:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,
    input  wire logic [7:0] bus_data_i,
    output      logic [7:0] bus_data_o,
    output      logic [3:0] red_o,
    output      logic [3:0] green_o,
    output      logic [3:0] blue_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

    logic                                  host_req_valid;
    logic                                  host_req_ready;
    logic                                  host_req_we;
    vid_pkg::vram_addr_t                   host_req_addr;
    vid_pkg::vram_word_t                   host_req_wdata;
    logic                                  fetch_valid;
    vid_pkg::vram_addr_t                   fetch_addr;
    logic [vid_pkg::NUM_BANKS-1:0]         bank_sel;
    logic                                  bank_we;
    logic [$clog2(vid_pkg::BANK_DEPTH)-1:0] bank_addr;
    vid_pkg::vram_word_t                   bank_wdata;
    vid_pkg::vram_word_t                   bank_rdata [vid_pkg::NUM_BANKS];
    logic                                  tag_read;
    logic                                  tag_vid;
    logic [$clog2(vid_pkg::NUM_BANKS)-1:0] tag_bank;
    vid_pkg::vram_word_t                   rdata;
    logic                                  vid_rdata_valid;
    logic                                  host_rdata_valid;
    logic                                  pal_we;
    logic [3:0]                            pal_idx;
    vid_pkg::rgb_t                         pal_wdata;
    logic                                  video_enable;

    host_regs host_regs (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .host_req_ready_i(host_req_ready), .host_rdata_valid_i(host_rdata_valid),
        .rdata_i(rdata), .host_req_valid_o(host_req_valid), .host_req_we_o(host_req_we),
        .host_req_addr_o(host_req_addr), .host_req_wdata_o(host_req_wdata),
        .pal_we_o(pal_we), .pal_idx_o(pal_idx), .pal_wdata_o(pal_wdata),
        .video_enable_o(video_enable)
    );

    vram_arbiter vram_arbiter (
        .clk(clk), .reset_i(reset_i),
        .fetch_valid_i(fetch_valid), .fetch_addr_i(fetch_addr),
        .host_req_valid_i(host_req_valid), .host_req_we_i(host_req_we),
        .host_req_addr_i(host_req_addr), .host_req_wdata_i(host_req_wdata),
        .host_req_ready_o(host_req_ready), .bank_sel_o(bank_sel), .bank_we_o(bank_we),
        .bank_addr_o(bank_addr), .bank_wdata_o(bank_wdata),
        .tag_read_o(tag_read), .tag_vid_o(tag_vid), .tag_bank_o(tag_bank)
    );

    // word address low bits pick the bank
    for (genvar i = 0; i < vid_pkg::NUM_BANKS; i++) begin : g_bank
        sync_ram #(
            .data_t (vid_pkg::vram_word_t),
            .DEPTH  (vid_pkg::BANK_DEPTH)
        ) bank (
            .clk(clk), .sel_i(bank_sel[i]), .we_i(bank_we),
            .addr_i(bank_addr), .wdata_i(bank_wdata), .rdata_o(bank_rdata[i])
        );
    end

    vram_read_return vram_read_return (
        .clk(clk), .reset_i(reset_i),
        .tag_read_i(tag_read), .tag_vid_i(tag_vid), .tag_bank_i(tag_bank),
        .bank_rdata_i(bank_rdata), .rdata_o(rdata),
        .vid_rdata_valid_o(vid_rdata_valid), .host_rdata_valid_o(host_rdata_valid)
    );

    video_engine video_engine (
        .clk(clk), .reset_i(reset_i), .enable_i(video_enable),
        .vid_rdata_valid_i(vid_rdata_valid), .rdata_i(rdata),
        .pal_we_i(pal_we), .pal_idx_i(pal_idx), .pal_wdata_i(pal_wdata),
        .fetch_valid_o(fetch_valid), .fetch_addr_o(fetch_addr),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

endmodule

`default_nettype wire

// ==== dv/vidcore_tb.sv ====
/*
 * testbench for the bitmap video controller
 * host bus driver, vram and palette model, raster and pixel checker
 */
`default_nettype none
`timescale 1ns/1ns

module vidcore_tb;

    localparam int FRAME_CYCLES = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL;
    localparam int NUM_PHASES   = 6;    // reset, palette, vram, readback, video, live update
    localparam int TIMEOUT      = 3 * FRAME_CYCLES * NUM_PHASES + 1000;
    localparam int SHOWN_WORDS  = vid_pkg::WORDS_PER_LINE * vid_pkg::V_VISIBLE;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [1:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    vid_pkg::vram_word_t vram_m [SHOWN_WORDS];          // words on screen
    vid_pkg::rgb_t       pal_m  [vid_pkg::PAL_ENTRIES];
    int          checks   = 0;
    int          errors   = 0;
    int          de_cnt   = 0;     // de cycles in current line
    int          hs_cnt   = 0;
    int          line_cnt = 0;     // de lines since last vsync
    logic        de_prev  = 1'b0;
    logic        hs_prev  = 1'b0;
    logic        vs_prev  = 1'b0;
    logic        synced   = 1'b0;  // a vsync seen, line numbers known
    logic [31:0] rnd;
    logic [7:0]  rd_hi;
    logic [7:0]  rd_lo;
    int          addr;

    vidcore_top DUT (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_bus(input logic cs_n, input logic rd_nwr, input logic [1:0] reg_num,
                             input logic bytesel, input logic [7:0] data);
        bus_cs_n_i    <= cs_n;
        bus_rd_nwr_i  <= rd_nwr;
        bus_reg_num_i <= reg_num;
        bus_bytesel_i <= bytesel;
        bus_data_i    <= data;
    endtask

    // high byte, low byte, then two idle cycles before the next access
    task automatic bus_write(input int reg_num, input logic [15:0] value);
        @(posedge clk);
        drive_bus(vid_pkg::CS_ENABLED, vid_pkg::RNW_WRITE, 2'(reg_num), 1'b0, value[15:8]);
        @(posedge clk);
        drive_bus(vid_pkg::CS_ENABLED, vid_pkg::RNW_WRITE, 2'(reg_num), 1'b1, value[7:0]);
        @(posedge clk);
        drive_bus(~vid_pkg::CS_ENABLED, vid_pkg::RNW_READ, 2'd0, 1'b0, 8'h00);
        @(posedge clk);
    endtask

    task automatic bus_read(input int reg_num, input logic bytesel, output logic [7:0] data);
        @(posedge clk);
        drive_bus(vid_pkg::CS_ENABLED, vid_pkg::RNW_READ, 2'(reg_num), bytesel, 8'h00);
        @(posedge clk);
        drive_bus(~vid_pkg::CS_ENABLED, vid_pkg::RNW_READ, 2'd0, 1'b0, 8'h00);
        @(negedge clk);
        data = bus_data_o;      // byte lands on the edge that samples the read
    endtask

    // palette colour of visible pixel n on line y, high nibble shown first
    function automatic vid_pkg::rgb_t expected_pixel(input int y, input int n);
        vid_pkg::vram_word_t word;
        int                  shift;
        logic [3:0]          idx;
        word  = vram_m[y * vid_pkg::WORDS_PER_LINE + n / vid_pkg::PIX_PER_WORD];
        shift = 4 * (vid_pkg::PIX_PER_WORD - 1 - n % vid_pkg::PIX_PER_WORD);
        idx   = 4'(word >> shift);
        return pal_m[idx];
    endfunction

    // raster and pixel checker, outputs settled mid cycle
    always @(negedge clk) begin
        if (reset_i == 1'b0) begin
            if (dv_de_o) begin
                if (synced && line_cnt < vid_pkg::V_VISIBLE && de_cnt < vid_pkg::H_VISIBLE) begin
                    check_value("rgb", {red_o, green_o, blue_o}, expected_pixel(line_cnt, de_cnt));
                end
                de_cnt++;
            end else begin
                check_value("rgb", {red_o, green_o, blue_o}, 0);  // black in blanking
            end
            if (de_prev && !dv_de_o) begin
                check_value("dv_de_o cycles per line", de_cnt, vid_pkg::H_VISIBLE);
                de_cnt = 0;
                line_cnt++;
            end
            if (hsync_o) begin
                hs_cnt++;
            end
            if (hs_prev && !hsync_o) begin
                check_value("hsync_o cycles", hs_cnt, vid_pkg::H_SYNC_END - vid_pkg::H_SYNC_START);
                hs_cnt = 0;
            end
            if (vsync_o && !vs_prev) begin
                check_value("dv_de_o lines per frame", line_cnt, vid_pkg::V_VISIBLE);
                line_cnt = 0;
                synced   = 1'b1;
            end
            de_prev = dv_de_o;
            hs_prev = hsync_o;
            vs_prev = vsync_o;
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout after %0d cycles, checks %0d, errors %0d", TIMEOUT, checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rnd           = $urandom(32'h60a0);
        reset_i       = 1'b1;
        bus_cs_n_i    = ~vid_pkg::CS_ENABLED;
        bus_rd_nwr_i  = vid_pkg::RNW_READ;
        bus_reg_num_i = 2'd0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        // video off, outputs quiet for a whole frame
        @(negedge clk);
        check_value("bus_data_o", bus_data_o, 0);
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            check_value("dv_de_o", dv_de_o, 0);
            check_value("hsync_o", hsync_o, 0);
            check_value("vsync_o", vsync_o, 0);
        end

        // palette entry picked by the address register
        for (int i = 0; i < vid_pkg::PAL_ENTRIES; i++) begin
            rnd      = $urandom;
            pal_m[i] = rnd[11:0];
            bus_write(vid_pkg::REG_ADDR, 16'(i));
            bus_write(vid_pkg::REG_PAL, {4'h0, pal_m[i]});
        end
        bus_write(vid_pkg::REG_ADDR, 16'h0000);
        for (int i = 0; i < SHOWN_WORDS; i++) begin
            rnd       = $urandom;
            vram_m[i] = rnd[15:0];
            bus_write(vid_pkg::REG_DATA, vram_m[i]);   // address steps on its own
        end

        // read-ahead into the read latch
        repeat (16) begin
            addr = $urandom_range(SHOWN_WORDS - 1, 0);
            bus_write(vid_pkg::REG_ADDR, 16'(addr));
            repeat (8) @(posedge clk);
            bus_read(vid_pkg::REG_DATA, 1'b0, rd_hi);
            bus_read(vid_pkg::REG_DATA, 1'b1, rd_lo);
            check_value("bus_data_o", {rd_hi, rd_lo}, vram_m[addr]);
        end

        bus_write(vid_pkg::REG_CTRL, 16'h0001);
        @(posedge vsync_o);
        @(posedge vsync_o);     // one full frame checked against the model

        // rewrite during the vsync line, new words due in the next frame
        repeat (3) begin
            addr = $urandom_range(SHOWN_WORDS - 3, 0);
            bus_write(vid_pkg::REG_ADDR, 16'(addr));
            for (int k = 0; k < 3; k++) begin
                rnd              = $urandom;
                vram_m[addr + k] = rnd[15:0];
                bus_write(vid_pkg::REG_DATA, vram_m[addr + k]);
            end
            @(posedge vsync_o);
        end

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vidcore.f ====
verilog/vid_pkg.sv
verilog/sync_ram.sv
verilog/host_regs.sv
verilog/vram_arbiter.sv
verilog/vram_read_return.sv
verilog/video_engine.sv
verilog/vidcore_top.sv
dv/vidcore_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, decide on the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vidcore.f --top-module vidcore_tb -o vidcore_sim
./obj_dir/vidcore_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
